// File: verilog/debug_pkg.sv
package debug_pkg;

	//////////////////////////////////////////////////
	// Processor side
	//////////////////////////////////////////////////
	localparam int word_len = 32;
	localparam int addr_len = 5;

	// Host command bytes ('c', 's', 'd')
	localparam logic [7:0] cmd_run  = 8'h63;
	localparam logic [7:0] cmd_step = 8'h73;
	localparam logic [7:0] cmd_dump = 8'h64;

	//////////////////////////////////////////////////
	// Dump layout
	//////////////////////////////////////////////////
	localparam int num_regs      = 32;
	localparam int num_mem_words = 16;
	// PC first, then registers, then data memory
	localparam int dump_words    = 1 + num_regs + num_mem_words;
	localparam int word_bytes    = 4;

	localparam int word_idx_len = $clog2(dump_words);
	localparam int byte_idx_len = $clog2(word_bytes);

	localparam logic [word_idx_len-1:0] mem_base_idx  = word_idx_len'(1 + num_regs);
	localparam logic [word_idx_len-1:0] last_word_idx = word_idx_len'(dump_words - 1);
	localparam logic [byte_idx_len-1:0] last_byte_idx = byte_idx_len'(word_bytes - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_run,
		st_step,
		st_dump_send,
		st_dump_wait
	} dbg_state_t;

endpackage

// File: verilog/uart_pkg.sv
package uart_pkg;

	// Frame format, 8N1
	localparam int data_bits  = 8;
	localparam int oversample = 16;

	// One tick every tick_div clocks
	localparam int tick_div     = 2;
	localparam int tick_cnt_len = $clog2(tick_div);

	// Counter widths and compare points
	localparam int sample_cnt_len = $clog2(oversample);
	localparam int bit_cnt_len    = $clog2(data_bits);

	localparam logic [tick_cnt_len-1:0]   last_tick_cnt = tick_cnt_len'(tick_div - 1);
	localparam logic [sample_cnt_len-1:0] mid_sample    = sample_cnt_len'(oversample / 2 - 1);
	localparam logic [sample_cnt_len-1:0] last_sample   = sample_cnt_len'(oversample - 1);
	localparam logic [bit_cnt_len-1:0]    last_bit      = bit_cnt_len'(data_bits - 1);

endpackage

// File: verilog/baud_tick_gen.sv
`timescale 1ns/1ns

module baud_tick_gen import uart_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	logic [tick_cnt_len-1:0] tick_cnt;

	// Free running divider
	always_ff @(posedge clk) begin
		if (reset) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else begin
			if (tick_cnt == last_tick_cnt) begin
				tick_cnt <= '0;
				tick     <= 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
				tick     <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 rx,
	output logic [data_bits-1:0] rx_data,
	output logic                 rx_done
);

	typedef enum logic [1:0] {
		rs_idle,
		rs_start,
		rs_bits,
		rs_stop
	} rx_state_t;

	rx_state_t                 state;
	logic                      rx_meta;
	logic                      rx_sync;
	logic                      rx_prev;
	logic [sample_cnt_len-1:0] sample_cnt;
	logic [bit_cnt_len-1:0]    bit_cnt;
	logic [data_bits-1:0]      shift;

	// Line idles high, so the flops come out of reset at 1
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	//////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= rs_idle;
			sample_cnt <= '0;
			bit_cnt    <= '0;
			rx_done    <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				rs_idle: begin
					// Falling edge marks a start bit
					if (rx_prev && !rx_sync) begin
						state      <= rs_start;
						sample_cnt <= '0;
					end
				end
				rs_start: begin
					if (tick) begin
						if (sample_cnt == mid_sample) begin
							sample_cnt <= '0;
							bit_cnt    <= '0;
							// Glitch if the line is already back high
							state      <= rx_sync ? rs_idle : rs_bits;
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
				end
				rs_bits: begin
					if (tick) begin
						if (sample_cnt == last_sample) begin
							sample_cnt <= '0;
							if (bit_cnt == last_bit)
								state <= rs_stop;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
				end
				rs_stop: begin
					if (tick) begin
						if (sample_cnt == last_sample) begin
							// Bad stop bit, byte is lost
							rx_done <= rx_sync;
							state   <= rs_idle;
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
				end
				default: state <= rs_idle;
			endcase
		end
	end

	// Mid-bit sample, LSB arrives first
	always_ff @(posedge clk) begin
		if (state == rs_bits && tick && sample_cnt == last_sample)
			shift <= {rx_sync, shift[data_bits-1:1]};
	end

	assign rx_data = shift;

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 tx_start,
	input  logic [data_bits-1:0] tx_data,
	output logic                 tx,
	output logic                 tx_done
);

	typedef enum logic [1:0] {
		ts_idle,
		ts_start,
		ts_bits,
		ts_stop
	} tx_state_t;

	tx_state_t                 state;
	logic [sample_cnt_len-1:0] sample_cnt;
	logic [bit_cnt_len-1:0]    bit_cnt;
	logic [data_bits-1:0]      shift;
	logic                      bit_end;

	assign bit_end = tick && (sample_cnt == last_sample);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ts_idle;
			sample_cnt <= '0;
			bit_cnt    <= '0;
			tx         <= 1'b1;
			tx_done    <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tick && state != ts_idle)
				sample_cnt <= sample_cnt + 1'b1;
			case (state)
				ts_idle: begin
					tx <= 1'b1;
					if (tx_start) begin
						state      <= ts_start;
						sample_cnt <= '0;
						tx         <= 1'b0;
					end
				end
				ts_start: begin
					if (bit_end) begin
						state   <= ts_bits;
						bit_cnt <= '0;
						tx      <= shift[0];
					end
				end
				ts_bits: begin
					if (bit_end) begin
						if (bit_cnt == last_bit) begin
							state <= ts_stop;
							tx    <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							tx      <= shift[1];
						end
					end
				end
				ts_stop: begin
					if (bit_end) begin
						state   <= ts_idle;
						tx_done <= 1'b1;
					end
				end
				default: state <= ts_idle;
			endcase
		end
	end

	// Byte latch and shifter
	always_ff @(posedge clk) begin
		if (state == ts_idle && tx_start)
			shift <= tx_data;
		else if (state == ts_bits && bit_end)
			shift <= shift >> 1;
	end

endmodule

// File: verilog/state_collector.sv
`timescale 1ns/1ns

module state_collector import debug_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                restart,
	input  logic                next,
	input  logic [word_len-1:0] cpu_pc,
	input  logic [word_len-1:0] reg_data,
	input  logic [word_len-1:0] mem_data,
	output logic [addr_len-1:0] debug_addr,
	output logic [7:0]          collector_byte,
	output logic                collector_last
);

	logic [word_idx_len-1:0] word_idx;
	logic [byte_idx_len-1:0] byte_idx;
	logic [word_len-1:0]     word;

	//////////////////////////////////////////////////
	// Position in the dump
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			word_idx <= '0;
			byte_idx <= '0;
		end else if (restart) begin
			word_idx <= '0;
			byte_idx <= '0;
		end else if (next) begin
			if (byte_idx == last_byte_idx) begin
				byte_idx <= '0;
				// Wraps so a finished dump leaves us at the PC again
				if (word_idx == last_word_idx)
					word_idx <= '0;
				else
					word_idx <= word_idx + 1'b1;
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Word select
	//////////////////////////////////////////////////
	always_comb begin
		debug_addr = '0;
		word       = cpu_pc;
		if (word_idx >= mem_base_idx) begin
			// Data memory words
			debug_addr = addr_len'(word_idx - mem_base_idx);
			word       = mem_data;
		end else if (word_idx != '0) begin
			// Register file, index 1 is r0
			debug_addr = addr_len'(word_idx - 1'b1);
			word       = reg_data;
		end
	end

	// LSB first
	assign collector_byte = word[{byte_idx, 3'b000} +: 8];

	assign collector_last = (word_idx == last_word_idx) && (byte_idx == last_byte_idx);

endmodule

// File: verilog/debug_fsm.sv
`timescale 1ns/1ns

module debug_fsm import debug_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] rx_data,
	input  logic       rx_done,
	input  logic       tx_done,
	input  logic       cpu_halt,
	input  logic [7:0] collector_byte,
	input  logic       collector_last,
	output logic       cpu_enable,
	output logic       tx_start,
	output logic [7:0] tx_data,
	output logic       collector_restart,
	output logic       collector_next
);

	dbg_state_t state;

	// Command decode
	logic is_run;
	logic is_step;
	logic is_dump;
	logic dump_now;

	assign is_run  = (rx_data == cmd_run);
	assign is_step = (rx_data == cmd_step);
	assign is_dump = (rx_data == cmd_dump);

	// Halted core, nothing to run, go straight to the dump
	assign dump_now = is_dump || (cpu_halt && (is_run || is_step));

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			cpu_enable <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				st_idle: begin
					// Only here are host bytes looked at
					if (rx_done) begin
						if (dump_now) begin
							state <= st_dump_send;
						end else if (is_run) begin
							state      <= st_run;
							cpu_enable <= 1'b1;
						end else if (is_step) begin
							state      <= st_step;
							cpu_enable <= 1'b1;
						end
					end
				end
				st_run: begin
					if (cpu_halt) begin
						cpu_enable <= 1'b0;
						state      <= st_dump_send;
					end
				end
				st_step: begin
					// Single clock of enable
					cpu_enable <= 1'b0;
					state      <= st_dump_send;
				end
				st_dump_send: begin
					tx_start <= 1'b1;
					state    <= st_dump_wait;
				end
				st_dump_wait: begin
					if (tx_done) begin
						if (collector_last)
							state <= st_idle;
						else
							state <= st_dump_send;
					end
				end
				default: begin
					state      <= st_idle;
					cpu_enable <= 1'b0;
				end
			endcase
		end
	end

	// Byte handed to the transmitter with tx_start
	always_ff @(posedge clk) begin
		if (state == st_dump_send)
			tx_data <= collector_byte;
	end

	//////////////////////////////////////////////////
	// Collector steering
	//////////////////////////////////////////////////

	// Held at word 0 byte 0 whenever idle
	assign collector_restart = (state == st_idle);

	// Advance once the current byte is on the wire
	assign collector_next = (state == st_dump_wait) && tx_done;

endmodule

// File: verilog/debug_unit_top.sv
`timescale 1ns/1ns

module debug_unit_top import debug_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                uart_rx_line,
	output logic                uart_tx_line,
	output logic                cpu_enable,
	input  logic                cpu_halt,
	input  logic [word_len-1:0] cpu_pc,
	output logic [addr_len-1:0] debug_addr,
	input  logic [word_len-1:0] reg_data,
	input  logic [word_len-1:0] mem_data
);

	logic       tick;
	logic [7:0] rx_data;
	logic       rx_done;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_done;
	logic       collector_restart;
	logic       collector_next;
	logic [7:0] collector_byte;
	logic       collector_last;

	//////////////////////////////////////////////////
	// Serial side
	//////////////////////////////////////////////////
	baud_tick_gen u_baud_tick_gen (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	uart_rx u_uart_rx (
		.clk    (clk),
		.reset  (reset),
		.tick   (tick),
		.rx     (uart_rx_line),
		.rx_data(rx_data),
		.rx_done(rx_done)
	);

	uart_tx u_uart_tx (
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.tx      (uart_tx_line),
		.tx_done (tx_done)
	);

	//////////////////////////////////////////////////
	// Processor side
	//////////////////////////////////////////////////
	state_collector u_state_collector (
		.clk           (clk),
		.reset         (reset),
		.restart       (collector_restart),
		.next          (collector_next),
		.cpu_pc        (cpu_pc),
		.reg_data      (reg_data),
		.mem_data      (mem_data),
		.debug_addr    (debug_addr),
		.collector_byte(collector_byte),
		.collector_last(collector_last)
	);

	debug_fsm u_debug_fsm (
		.clk              (clk),
		.reset            (reset),
		.rx_data          (rx_data),
		.rx_done          (rx_done),
		.tx_done          (tx_done),
		.cpu_halt         (cpu_halt),
		.collector_byte   (collector_byte),
		.collector_last   (collector_last),
		.cpu_enable       (cpu_enable),
		.tx_start         (tx_start),
		.tx_data          (tx_data),
		.collector_restart(collector_restart),
		.collector_next   (collector_next)
	);

endmodule

// File: verification/debug_unit_tb.sv
`timescale 1ns/1ns

module debug_unit_tb import debug_pkg::*, uart_pkg::*; ();

	//////////////////////////////////////////////////
	// Timing of the serial line and the run
	//////////////////////////////////////////////////
	localparam int bit_clocks     = oversample * tick_div;
	localparam int frame_clocks   = bit_clocks * (data_bits + 2);
	localparam int frame_slack    = 8;
	localparam int dump_frames    = dump_words * word_bytes;
	localparam int num_dumps      = 6;
	localparam int junk_count     = 6;
	localparam int settle_frames  = 4;
	localparam int max_run_cycles = 64;
	localparam int total_frames   = num_dumps * (1 + dump_frames + settle_frames)
		+ 2 + junk_count + settle_frames;
	localparam int dump_limit     = dump_frames * (frame_clocks + frame_slack)
		+ max_run_cycles + 2 * frame_clocks;
	localparam int timeout_cycles = total_frames * (frame_clocks + frame_slack)
		+ max_run_cycles + 2000;

	logic        clk;
	logic        reset;
	logic        uart_rx_line;
	logic        uart_tx_line;
	logic        cpu_enable;
	logic        cpu_halt;
	logic [31:0] cpu_pc;
	logic [4:0]  debug_addr;
	logic [31:0] reg_data;
	logic [31:0] mem_data;

	// Processor model state
	logic [31:0] pc = '0;
	logic [31:0] halt_pc = '1;
	int          enable_cycles = 0;

	logic [15:0] lfsr;
	logic [7:0]  tx_bytes[$];
	logic [7:0]  mon_byte;
	int          mon_bit;
	int          cycle_count = 0;
	int          error_count = 0;
	int          check_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_error_base = 0;

	debug_unit_top UUT (
		.clk         (clk),
		.reset       (reset),
		.uart_rx_line(uart_rx_line),
		.uart_tx_line(uart_tx_line),
		.cpu_enable  (cpu_enable),
		.cpu_halt    (cpu_halt),
		.cpu_pc      (cpu_pc),
		.debug_addr  (debug_addr),
		.reg_data    (reg_data),
		.mem_data    (mem_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Processor behind the debug port
	//////////////////////////////////////////////////
	// Halted core holds its pc even with the enable high
	always @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (cpu_enable && !cpu_halt)
			pc <= pc + 1;
	end

	always @(posedge clk) begin
		if (!reset && cpu_enable)
			enable_cycles <= enable_cycles + 1;
	end

	assign cpu_pc   = pc;
	assign cpu_halt = (pc == halt_pc);
	assign reg_data = pc * 65537 + 32'(debug_addr);
	assign mem_data = ~(pc + 32'(debug_addr));

	// Serial monitor, samples each bit in its middle
	always begin
		@(posedge clk);
		if (!reset && uart_tx_line === 1'b0) begin
			repeat (bit_clocks / 2) @(posedge clk);
			for (mon_bit = 0; mon_bit < data_bits; mon_bit++) begin
				repeat (bit_clocks) @(posedge clk);
				mon_byte[mon_bit] = uart_tx_line;
			end
			repeat (bit_clocks) @(posedge clk);
			if (uart_tx_line !== 1'b1) begin
				$display("Frame error at %0t: the stop bit on uart_tx_line was low", $time);
				error_count++;
			end
			tx_bytes.push_back(mon_byte);
		end
	end

	// Watchdog
	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the tests did not complete", cycle_count);
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int count, output logic [7:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	// Start bit, 8 data bits LSB first, stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			uart_rx_line <= frame[i];
			repeat (bit_clocks) @(posedge clk);
		end
	endtask

	task automatic send_junk();
		logic [7:0] b;
		do begin
			random_bits(8, b);
		end while (b == cmd_run || b == cmd_step || b == cmd_dump);
		send_byte(b);
	endtask

	task automatic check_dump(input logic [31:0] exp_pc);
		int w;
		int waited;
		logic [31:0] got;
		logic [31:0] expected;
		waited = 0;
		while (tx_bytes.size() < dump_frames && waited < dump_limit) begin
			@(posedge clk);
			waited++;
		end
		if (tx_bytes.size() < dump_frames) begin
			$display("Dump did not finish, only %0d of %0d bytes arrived",
				tx_bytes.size(), dump_frames);
			error_count++;
		end
		// Extra bytes would show up here
		repeat (settle_frames * frame_clocks) @(posedge clk);
		check_value("dump byte count", tx_bytes.size(), dump_frames);
		if (tx_bytes.size() >= dump_frames) begin
			for (w = 0; w < dump_words; w++) begin
				got = {tx_bytes[4*w+3], tx_bytes[4*w+2], tx_bytes[4*w+1], tx_bytes[4*w]};
				if (w == 0) begin
					check_value("dump pc", got, exp_pc);
				end else if (w <= num_regs) begin
					expected = exp_pc * 65537 + 32'(w - 1);
					check_value($sformatf("dump reg[%0d]", w - 1), got, expected);
				end else begin
					expected = ~(exp_pc + 32'(w - 1 - num_regs));
					check_value($sformatf("dump mem[%0d]", w - 1 - num_regs), got, expected);
				end
			end
		end
		tx_bytes.delete();
	endtask

	task automatic begin_test();
		test_error_base = error_count;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (error_count == test_error_base) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: fail with %0d errors", name, error_count - test_error_base);
			tests_failed++;
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	initial begin
		int enable_base;
		logic [7:0] r;
		reset        = 1'b1;
		uart_rx_line = 1'b1;
		lfsr         = 16'd80;
		random_bits(5, r);
		halt_pc = 32'd20 + 32'(r);
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (8) @(posedge clk);

		begin_test();
		send_byte(cmd_dump);
		check_dump(32'd0);
		end_test("dump_after_reset");

		begin_test();
		enable_base = enable_cycles;
		send_byte(cmd_step);
		check_dump(32'd1);
		check_value("cpu_enable cycles", enable_cycles - enable_base, 1);
		end_test("single_step");

		// Steps from pc 1 to the halt, plus the cycle that sees the halt
		begin_test();
		enable_base = enable_cycles;
		send_byte(cmd_run);
		check_dump(halt_pc);
		check_value("cpu_enable cycles", enable_cycles - enable_base, halt_pc);
		end_test("run_to_halt");

		begin_test();
		enable_base = enable_cycles;
		send_byte(cmd_run);
		check_dump(halt_pc);
		send_byte(cmd_step);
		check_dump(halt_pc);
		check_value("cpu_enable cycles", enable_cycles - enable_base, 0);
		end_test("command_while_halted");

		begin_test();
		enable_base = enable_cycles;
		repeat (junk_count) send_junk();
		repeat (settle_frames * frame_clocks) @(posedge clk);
		check_value("frames after junk", tx_bytes.size(), 0);
		send_byte(cmd_dump);
		// Host bytes landing in the middle of the dump
		send_byte(cmd_run);
		send_junk();
		check_dump(halt_pc);
		check_value("cpu_enable cycles", enable_cycles - enable_base, 0);
		end_test("junk_bytes");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: flist.f
verilog/debug_pkg.sv
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/state_collector.sv
verilog/debug_fsm.sv
verilog/debug_unit_top.sv
verification/debug_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing -f flist.f --top-module debug_unit_tb \
	-Mdir "$build_dir" -o debug_unit_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/debug_unit_sim" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$sim_log"; then
	exit 1
fi
exit 0
